// File: design/cu_pkg.sv
`default_nettype none

package cu_pkg;

	// ----------------------------------------
	// instruction word
	// ----------------------------------------
	typedef logic [7:0] instr_t;
	typedef logic [3:0] operand_t;

	typedef enum logic [3:0] {
		NOP     = 4'h0,
		CLAC    = 4'h1,
		LDAC    = 4'h2,
		STAC    = 4'h3,
		MVR     = 4'h4,
		MVAC    = 4'h5,
		MUL     = 4'h6,
		ADD     = 4'h7,
		SUB     = 4'h8,
		DIV     = 4'h9,
		JPNZ    = 4'hA,
		INCAC   = 4'hB,
		DECAC   = 4'hC,
		END_PRG = 4'hF
	} opcode_t;

	// operand codes in the lower nibble.
	localparam operand_t OPD_LOAD  = 4'd0;
	localparam operand_t OPD_STORE = 4'd0;
	localparam operand_t OPD_JUMP  = 4'd0;
	localparam operand_t OPD_A     = 4'd1;
	localparam operand_t OPD_B     = 4'd2;
	localparam operand_t OPD_C     = 4'd3;
	localparam operand_t OPD_SR    = 4'd4;
	localparam operand_t OPD_CDR   = 4'd5;
	localparam operand_t OPD_PR    = 4'd6;
	localparam operand_t OPD_R     = 4'd7;
	localparam operand_t OPD_SR_IR = 4'd8;
	localparam operand_t OPD_NOC   = 4'd9;
	localparam operand_t OPD_CID   = 4'd10;
	localparam operand_t OPD_CLA   = 4'd11;
	localparam operand_t OPD_LAST  = 4'd15;

	// ----------------------------------------
	// control word fields
	// ----------------------------------------
	typedef logic [4:0] mux_sel_t;
	typedef logic [3:0] load_sel_t;
	typedef logic [2:0] inc_sel_t;
	typedef logic [2:0] alu_op_t;

	localparam mux_sel_t SEL_DR    = 5'd0;
	localparam mux_sel_t SEL_PR    = 5'd1;
	localparam mux_sel_t SEL_SR    = 5'd2;
	localparam mux_sel_t SEL_CDR   = 5'd3;
	localparam mux_sel_t SEL_R     = 5'd4;
	localparam mux_sel_t SEL_TR    = 5'd5;
	localparam mux_sel_t SEL_A     = 5'd6;
	localparam mux_sel_t SEL_B     = 5'd7;
	localparam mux_sel_t SEL_C     = 5'd8;
	localparam mux_sel_t SEL_AC    = 5'd9;
	localparam mux_sel_t SEL_DRAM  = 5'd10;
	localparam mux_sel_t SEL_IRAM  = 5'd11;
	localparam mux_sel_t SEL_DRTR  = 5'd12; // DR and TR joined.
	localparam mux_sel_t SEL_ACINV = 5'd13;
	localparam mux_sel_t SEL_CLA   = 5'd14;
	localparam mux_sel_t SEL_NOC   = 5'd15;
	localparam mux_sel_t SEL_CID   = 5'd16;
	localparam mux_sel_t SEL_NONE  = 5'd31; // bus floats.

	localparam load_sel_t LOAD_OFF = 4'd0;
	localparam load_sel_t LOAD_PC  = 4'd1;
	localparam load_sel_t LOAD_IR  = 4'd2;
	localparam load_sel_t LOAD_AR  = 4'd3;
	localparam load_sel_t LOAD_DR  = 4'd4;
	localparam load_sel_t LOAD_PR  = 4'd5;
	localparam load_sel_t LOAD_SR  = 4'd6;
	localparam load_sel_t LOAD_CDR = 4'd7;
	localparam load_sel_t LOAD_R   = 4'd8;
	localparam load_sel_t LOAD_TR  = 4'd9;
	localparam load_sel_t LOAD_A   = 4'd10;
	localparam load_sel_t LOAD_B   = 4'd11;
	localparam load_sel_t LOAD_C   = 4'd12;
	localparam load_sel_t LOAD_AC  = 4'd13;
	localparam load_sel_t LOAD_CLA = 4'd14;
	localparam load_sel_t LOAD_NOC = 4'd15;

	localparam inc_sel_t INC_OFF = 3'd0;
	localparam inc_sel_t INC_PC  = 3'd1;
	localparam inc_sel_t INC_R   = 3'd2;
	localparam inc_sel_t INC_A   = 3'd3;
	localparam inc_sel_t INC_B   = 3'd4;
	localparam inc_sel_t INC_C   = 3'd5;
	localparam inc_sel_t INC_AC  = 3'd6;
	localparam inc_sel_t INC_AR  = 3'd7;

	localparam alu_op_t ALU_IDLE = 3'd0;
	localparam alu_op_t ALU_MUL  = 3'd1;
	localparam alu_op_t ALU_ADD  = 3'd2;
	localparam alu_op_t ALU_SUB  = 3'd3;
	localparam alu_op_t ALU_DIV  = 3'd4;

	// ----------------------------------------
	// sequencer states
	// ----------------------------------------
	typedef enum logic [6:0] {
		S_FETCH1, S_FETCH2, S_FETCH3, S_FETCH4,
		S_NOP, S_CLAC,
		S_LDAC1, S_LDAC2, S_LDAC3, S_LDAC4, S_LDAC5, S_LDAC6,
		S_LDAC7, S_LDAC8, S_LDAC9, S_LDAC10, S_LDAC11,
		S_STAC1, S_STAC2, S_STAC3, S_STAC4, S_STAC5, S_STAC6, S_STAC7,
		S_MVR_SR, S_MVR_CDR, S_MVR_A, S_MVR_CID, S_MVR_CLA,
		S_MVAC_A, S_MVAC_B, S_MVAC_C, S_MVAC_CDR, S_MVAC_SR,
		S_MVAC_PR, S_MVAC_R, S_MVAC_NOC, S_MVAC_CLA,
		S_MUL_PR, S_ADD_CDR, S_ADD_SR, S_ADD_SR_IR,
		S_SUB_R, S_SUB_CDR, S_DIV_NOC,
		S_JPNZ_Y1, S_JPNZ_Y2, S_JPNZ_Y3, S_JPNZ_N,
		S_LAST_Y1, S_LAST_Y2, S_LAST_Y3, S_LAST_N,
		S_INCAC, S_DECAC, S_IDLE
	} cu_state_t;

endpackage

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder
(
	input wire cu_pkg::instr_t instruction,
	input wire zflag,
	output cu_pkg::cu_state_t entry_state
);

	cu_pkg::opcode_t opcode;
	cu_pkg::operand_t operand;

	assign opcode = cu_pkg::opcode_t'(instruction[7:4]);
	assign operand = instruction[3:0];

	always_comb
	begin
		entry_state = cu_pkg::S_IDLE; // illegal combos halt.
		case (opcode)
			cu_pkg::NOP: entry_state = cu_pkg::S_NOP;
			cu_pkg::CLAC: entry_state = cu_pkg::S_CLAC;
			cu_pkg::LDAC:
				if (operand == cu_pkg::OPD_LOAD)
					entry_state = cu_pkg::S_LDAC1;
			cu_pkg::STAC:
				if (operand == cu_pkg::OPD_STORE)
					entry_state = cu_pkg::S_STAC1;
			cu_pkg::MVR:
				case (operand)
					cu_pkg::OPD_SR: entry_state = cu_pkg::S_MVR_SR;
					cu_pkg::OPD_CDR: entry_state = cu_pkg::S_MVR_CDR;
					cu_pkg::OPD_A: entry_state = cu_pkg::S_MVR_A;
					cu_pkg::OPD_CID: entry_state = cu_pkg::S_MVR_CID;
					cu_pkg::OPD_CLA: entry_state = cu_pkg::S_MVR_CLA;
					default: entry_state = cu_pkg::S_IDLE;
				endcase
			cu_pkg::MVAC:
				case (operand)
					cu_pkg::OPD_A: entry_state = cu_pkg::S_MVAC_A;
					cu_pkg::OPD_B: entry_state = cu_pkg::S_MVAC_B;
					cu_pkg::OPD_C: entry_state = cu_pkg::S_MVAC_C;
					cu_pkg::OPD_CDR: entry_state = cu_pkg::S_MVAC_CDR;
					cu_pkg::OPD_SR: entry_state = cu_pkg::S_MVAC_SR;
					cu_pkg::OPD_PR: entry_state = cu_pkg::S_MVAC_PR;
					cu_pkg::OPD_R: entry_state = cu_pkg::S_MVAC_R;
					cu_pkg::OPD_NOC: entry_state = cu_pkg::S_MVAC_NOC;
					cu_pkg::OPD_CLA: entry_state = cu_pkg::S_MVAC_CLA;
					default: entry_state = cu_pkg::S_IDLE;
				endcase
			cu_pkg::MUL:
				if (operand == cu_pkg::OPD_PR)
					entry_state = cu_pkg::S_MUL_PR;
			cu_pkg::ADD:
				case (operand)
					cu_pkg::OPD_CDR: entry_state = cu_pkg::S_ADD_CDR;
					cu_pkg::OPD_SR: entry_state = cu_pkg::S_ADD_SR;
					cu_pkg::OPD_SR_IR: entry_state = cu_pkg::S_ADD_SR_IR;
					default: entry_state = cu_pkg::S_IDLE;
				endcase
			cu_pkg::SUB:
				case (operand)
					cu_pkg::OPD_R: entry_state = cu_pkg::S_SUB_R;
					cu_pkg::OPD_CDR: entry_state = cu_pkg::S_SUB_CDR;
					default: entry_state = cu_pkg::S_IDLE;
				endcase
			cu_pkg::DIV:
				if (operand == cu_pkg::OPD_NOC)
					entry_state = cu_pkg::S_DIV_NOC;
			// jump taken while zflag is low.
			cu_pkg::JPNZ:
				case (operand)
					cu_pkg::OPD_JUMP: entry_state = zflag ? cu_pkg::S_JPNZ_N : cu_pkg::S_JPNZ_Y1;
					cu_pkg::OPD_LAST: entry_state = zflag ? cu_pkg::S_LAST_N : cu_pkg::S_LAST_Y1;
					default: entry_state = cu_pkg::S_IDLE;
				endcase
			cu_pkg::INCAC: entry_state = cu_pkg::S_INCAC;
			cu_pkg::DECAC: entry_state = cu_pkg::S_DECAC;
			default: entry_state = cu_pkg::S_IDLE; // END_PRG too.
		endcase
	end

endmodule

`default_nettype wire

// File: design/micro_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module micro_sequencer
(
	input wire clk,
	input wire reset,
	input wire start_sig,
	input wire cu_pkg::cu_state_t entry_state,
	output cu_pkg::cu_state_t state,
	output logic rst_PC
);

	cu_pkg::cu_state_t next_state;

	always_comb
	begin
		case (state)
			// ----------------------------------------
			// fetch
			// ----------------------------------------
			cu_pkg::S_FETCH1: next_state = cu_pkg::S_FETCH2;
			cu_pkg::S_FETCH2: next_state = cu_pkg::S_FETCH3;
			cu_pkg::S_FETCH3: next_state = cu_pkg::S_FETCH4;
			cu_pkg::S_FETCH4: next_state = entry_state; // decode point.

			// ----------------------------------------
			// multi-step chains
			// ----------------------------------------
			cu_pkg::S_LDAC1: next_state = cu_pkg::S_LDAC2;
			cu_pkg::S_LDAC2: next_state = cu_pkg::S_LDAC3;
			cu_pkg::S_LDAC3: next_state = cu_pkg::S_LDAC4;
			cu_pkg::S_LDAC4: next_state = cu_pkg::S_LDAC5;
			cu_pkg::S_LDAC5: next_state = cu_pkg::S_LDAC6;
			cu_pkg::S_LDAC6: next_state = cu_pkg::S_LDAC7;
			cu_pkg::S_LDAC7: next_state = cu_pkg::S_LDAC8;
			cu_pkg::S_LDAC8: next_state = cu_pkg::S_LDAC9;
			cu_pkg::S_LDAC9: next_state = cu_pkg::S_LDAC10;
			cu_pkg::S_LDAC10: next_state = cu_pkg::S_LDAC11;
			cu_pkg::S_STAC1: next_state = cu_pkg::S_STAC2;
			cu_pkg::S_STAC2: next_state = cu_pkg::S_STAC3;
			cu_pkg::S_STAC3: next_state = cu_pkg::S_STAC4;
			cu_pkg::S_STAC4: next_state = cu_pkg::S_STAC5;
			cu_pkg::S_STAC5: next_state = cu_pkg::S_STAC6;
			cu_pkg::S_STAC6: next_state = cu_pkg::S_STAC7;
			cu_pkg::S_JPNZ_Y1: next_state = cu_pkg::S_JPNZ_Y2;
			cu_pkg::S_JPNZ_Y2: next_state = cu_pkg::S_JPNZ_Y3;
			cu_pkg::S_LAST_Y1: next_state = cu_pkg::S_LAST_Y2;
			cu_pkg::S_LAST_Y2: next_state = cu_pkg::S_LAST_Y3;
			cu_pkg::S_LAST_Y3: next_state = cu_pkg::S_IDLE; // program ends.

			// chain ends and single-step instructions.
			cu_pkg::S_LDAC11, cu_pkg::S_STAC7, cu_pkg::S_JPNZ_Y3,
			cu_pkg::S_JPNZ_N, cu_pkg::S_LAST_N,
			cu_pkg::S_NOP, cu_pkg::S_CLAC, cu_pkg::S_INCAC, cu_pkg::S_DECAC,
			cu_pkg::S_MVR_SR, cu_pkg::S_MVR_CDR, cu_pkg::S_MVR_A,
			cu_pkg::S_MVR_CID, cu_pkg::S_MVR_CLA,
			cu_pkg::S_MVAC_A, cu_pkg::S_MVAC_B, cu_pkg::S_MVAC_C,
			cu_pkg::S_MVAC_CDR, cu_pkg::S_MVAC_SR, cu_pkg::S_MVAC_PR,
			cu_pkg::S_MVAC_R, cu_pkg::S_MVAC_NOC, cu_pkg::S_MVAC_CLA,
			cu_pkg::S_MUL_PR, cu_pkg::S_ADD_CDR, cu_pkg::S_ADD_SR,
			cu_pkg::S_ADD_SR_IR, cu_pkg::S_SUB_R, cu_pkg::S_SUB_CDR,
			cu_pkg::S_DIV_NOC: next_state = cu_pkg::S_FETCH1;

			// start is active low in idle.
			cu_pkg::S_IDLE: next_state = start_sig ? cu_pkg::S_IDLE : cu_pkg::S_FETCH1;
			default: next_state = cu_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= cu_pkg::S_IDLE;
			rst_PC <= 1'b0;
		end
		else
		begin
			state <= next_state;
			rst_PC <= (state == cu_pkg::S_IDLE) && !start_sig; // one cycle on leaving idle.
		end
	end

endmodule

`default_nettype wire

// File: design/control_store.sv
`timescale 1ns/100ps
`default_nettype none

module control_store
(
	input wire clk,
	input wire reset,
	input wire cu_pkg::cu_state_t state,
	output cu_pkg::mux_sel_t mux_sig,
	output cu_pkg::load_sel_t load_decode_sig,
	output cu_pkg::alu_op_t alu_sig,
	output cu_pkg::inc_sel_t inc_decode_sig,
	output logic busy_sig,
	output logic clear_ac,
	output logic dec_ac,
	output logic iram_read,
	output logic dram_read,
	output logic dram_write
);

	cu_pkg::mux_sel_t mux_nxt;
	cu_pkg::load_sel_t load_nxt;
	cu_pkg::alu_op_t alu_nxt;
	cu_pkg::inc_sel_t inc_nxt;
	logic busy_nxt;
	logic clear_nxt;
	logic dec_nxt;
	logic iram_rd_nxt;
	logic dram_rd_nxt;
	logic dram_wr_nxt;

	// ----------------------------------------
	// control word per state
	// ----------------------------------------
	always_comb
	begin
		mux_nxt = cu_pkg::SEL_NONE;
		load_nxt = cu_pkg::LOAD_OFF;
		alu_nxt = cu_pkg::ALU_IDLE;
		inc_nxt = cu_pkg::INC_OFF;
		busy_nxt = (state != cu_pkg::S_IDLE);
		clear_nxt = 1'b0;
		dec_nxt = 1'b0;
		iram_rd_nxt = 1'b0;
		dram_rd_nxt = 1'b0;
		dram_wr_nxt = 1'b0;

		case (state)
			// fetch and operand address read share the same steps.
			cu_pkg::S_FETCH1, cu_pkg::S_LDAC1, cu_pkg::S_STAC1,
			cu_pkg::S_JPNZ_Y1, cu_pkg::S_LAST_Y1: iram_rd_nxt = 1'b1;
			cu_pkg::S_FETCH2, cu_pkg::S_LDAC2, cu_pkg::S_LDAC4,
			cu_pkg::S_STAC2, cu_pkg::S_STAC4,
			cu_pkg::S_JPNZ_Y2, cu_pkg::S_LAST_Y2:
			begin
				mux_nxt = cu_pkg::SEL_IRAM;
				load_nxt = cu_pkg::LOAD_DR;
			end
			cu_pkg::S_FETCH3:
			begin
				mux_nxt = cu_pkg::SEL_DR;
				load_nxt = cu_pkg::LOAD_IR;
				inc_nxt = cu_pkg::INC_PC;
			end
			cu_pkg::S_CLAC: clear_nxt = 1'b1;

			// address low byte to TR, then high byte.
			cu_pkg::S_LDAC3, cu_pkg::S_STAC3:
			begin
				mux_nxt = cu_pkg::SEL_DR;
				load_nxt = cu_pkg::LOAD_TR;
				inc_nxt = cu_pkg::INC_PC;
				iram_rd_nxt = 1'b1;
			end
			cu_pkg::S_LDAC5, cu_pkg::S_STAC5:
			begin
				mux_nxt = cu_pkg::SEL_DRTR;
				load_nxt = cu_pkg::LOAD_AR;
				inc_nxt = cu_pkg::INC_PC;
				dram_rd_nxt = (state == cu_pkg::S_LDAC5);
			end
			cu_pkg::S_LDAC6, cu_pkg::S_LDAC9: dram_rd_nxt = 1'b1;
			cu_pkg::S_LDAC7, cu_pkg::S_LDAC10:
			begin
				mux_nxt = cu_pkg::SEL_DRAM;
				load_nxt = cu_pkg::LOAD_DR;
			end
			cu_pkg::S_LDAC8:
			begin
				mux_nxt = cu_pkg::SEL_DR;
				load_nxt = cu_pkg::LOAD_TR;
				inc_nxt = cu_pkg::INC_AR;
				dram_rd_nxt = 1'b1;
			end
			cu_pkg::S_LDAC11:
			begin
				mux_nxt = cu_pkg::SEL_DRTR;
				load_nxt = cu_pkg::LOAD_AC;
			end

			// AC written as two bytes.
			cu_pkg::S_STAC6:
			begin
				mux_nxt = cu_pkg::SEL_AC;
				load_nxt = cu_pkg::LOAD_DR;
				dram_wr_nxt = 1'b1;
			end
			cu_pkg::S_STAC7:
			begin
				mux_nxt = cu_pkg::SEL_ACINV;
				load_nxt = cu_pkg::LOAD_DR;
				inc_nxt = cu_pkg::INC_AR;
				dram_wr_nxt = 1'b1;
			end

			// ----------------------------------------
			// register moves
			// ----------------------------------------
			cu_pkg::S_MVR_SR, cu_pkg::S_MVR_CDR, cu_pkg::S_MVR_A,
			cu_pkg::S_MVR_CID, cu_pkg::S_MVR_CLA:
			begin
				load_nxt = cu_pkg::LOAD_AC;
				case (state)
					cu_pkg::S_MVR_SR: mux_nxt = cu_pkg::SEL_SR;
					cu_pkg::S_MVR_CDR: mux_nxt = cu_pkg::SEL_CDR;
					cu_pkg::S_MVR_A: mux_nxt = cu_pkg::SEL_A;
					cu_pkg::S_MVR_CID: mux_nxt = cu_pkg::SEL_CID;
					default: mux_nxt = cu_pkg::SEL_CLA;
				endcase
			end
			cu_pkg::S_MVAC_A: {mux_nxt, load_nxt} = {cu_pkg::SEL_AC, cu_pkg::LOAD_A};
			cu_pkg::S_MVAC_B: {mux_nxt, load_nxt} = {cu_pkg::SEL_AC, cu_pkg::LOAD_B};
			cu_pkg::S_MVAC_C: {mux_nxt, load_nxt} = {cu_pkg::SEL_AC, cu_pkg::LOAD_C};
			cu_pkg::S_MVAC_CDR: {mux_nxt, load_nxt} = {cu_pkg::SEL_AC, cu_pkg::LOAD_CDR};
			cu_pkg::S_MVAC_SR: {mux_nxt, load_nxt} = {cu_pkg::SEL_AC, cu_pkg::LOAD_SR};
			cu_pkg::S_MVAC_PR: {mux_nxt, load_nxt} = {cu_pkg::SEL_AC, cu_pkg::LOAD_PR};
			cu_pkg::S_MVAC_R: {mux_nxt, load_nxt} = {cu_pkg::SEL_AC, cu_pkg::LOAD_R};
			cu_pkg::S_MVAC_NOC: {mux_nxt, load_nxt} = {cu_pkg::SEL_AC, cu_pkg::LOAD_NOC};
			cu_pkg::S_MVAC_CLA: {mux_nxt, load_nxt} = {cu_pkg::SEL_AC, cu_pkg::LOAD_CLA};

			// alu against one register.
			cu_pkg::S_MUL_PR: {mux_nxt, alu_nxt} = {cu_pkg::SEL_PR, cu_pkg::ALU_MUL};
			cu_pkg::S_ADD_CDR: {mux_nxt, alu_nxt} = {cu_pkg::SEL_CDR, cu_pkg::ALU_ADD};
			cu_pkg::S_ADD_SR: {mux_nxt, alu_nxt} = {cu_pkg::SEL_SR, cu_pkg::ALU_ADD};
			cu_pkg::S_ADD_SR_IR:
			begin
				{mux_nxt, alu_nxt} = {cu_pkg::SEL_SR, cu_pkg::ALU_ADD};
				inc_nxt = cu_pkg::INC_R;
			end
			cu_pkg::S_SUB_R: {mux_nxt, alu_nxt} = {cu_pkg::SEL_R, cu_pkg::ALU_SUB};
			cu_pkg::S_SUB_CDR: {mux_nxt, alu_nxt} = {cu_pkg::SEL_CDR, cu_pkg::ALU_SUB};
			cu_pkg::S_DIV_NOC: {mux_nxt, alu_nxt} = {cu_pkg::SEL_NOC, cu_pkg::ALU_DIV};

			cu_pkg::S_JPNZ_Y3, cu_pkg::S_LAST_Y3:
			begin
				mux_nxt = cu_pkg::SEL_DR;
				load_nxt = cu_pkg::LOAD_PC;
			end
			cu_pkg::S_JPNZ_N, cu_pkg::S_LAST_N: inc_nxt = cu_pkg::INC_PC; // skip target.
			cu_pkg::S_INCAC: inc_nxt = cu_pkg::INC_AC;
			cu_pkg::S_DECAC: dec_nxt = 1'b1;
			default: ; // FETCH4, NOP and idle carry no word.
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			mux_sig <= cu_pkg::SEL_NONE;
			load_decode_sig <= cu_pkg::LOAD_OFF;
			alu_sig <= cu_pkg::ALU_IDLE;
			inc_decode_sig <= cu_pkg::INC_OFF;
			busy_sig <= 1'b0;
			clear_ac <= 1'b0;
			dec_ac <= 1'b0;
			iram_read <= 1'b0;
			dram_read <= 1'b0;
			dram_write <= 1'b0;
		end
		else
		begin
			mux_sig <= mux_nxt;
			load_decode_sig <= load_nxt;
			alu_sig <= alu_nxt;
			inc_decode_sig <= inc_nxt;
			busy_sig <= busy_nxt;
			clear_ac <= clear_nxt;
			dec_ac <= dec_nxt;
			iram_read <= iram_rd_nxt;
			dram_read <= dram_rd_nxt;
			dram_write <= dram_wr_nxt;
		end
	end

endmodule

`default_nettype wire

// File: design/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit
(
	input wire clk,
	input wire reset,
	input wire cu_pkg::instr_t instruction,
	input wire zflag,
	input wire start_sig,
	output cu_pkg::mux_sel_t mux_sig,
	output cu_pkg::load_sel_t load_decode_sig,
	output cu_pkg::alu_op_t alu_sig,
	output cu_pkg::inc_sel_t inc_decode_sig,
	output logic busy_sig,
	output logic rst_PC,
	output logic clear_ac,
	output logic dec_ac,
	output logic iram_read,
	output logic dram_read,
	output logic dram_write
);

	cu_pkg::cu_state_t entry_state;
	cu_pkg::cu_state_t state;

	// ----------------------------------------
	// decode, sequence, control word
	// ----------------------------------------
	instr_decoder u_decoder
	(
		.instruction(instruction),
		.zflag(zflag),
		.entry_state(entry_state)
	);

	micro_sequencer u_sequencer
	(
		.clk(clk),
		.reset(reset),
		.start_sig(start_sig),
		.entry_state(entry_state),
		.state(state),
		.rst_PC(rst_PC)
	);

	control_store u_store
	(
		.clk(clk),
		.reset(reset),
		.state(state),
		.mux_sig(mux_sig),
		.load_decode_sig(load_decode_sig),
		.alu_sig(alu_sig),
		.inc_decode_sig(inc_decode_sig),
		.busy_sig(busy_sig),
		.clear_ac(clear_ac),
		.dec_ac(dec_ac),
		.iram_read(iram_read),
		.dram_read(dram_read),
		.dram_write(dram_write)
	);

endmodule

`default_nettype wire

// File: sim/tb_control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_control_unit;

	// {rst_PC, busy, mux, load, alu, inc, clear, dec, iram_rd, dram_rd, dram_wr}
	typedef logic [21:0] word_t;

	localparam int TIMEOUT = 50;
	localparam logic [4:0] FL_NONE = 5'b00000;
	localparam logic [4:0] FL_CLR = 5'b10000;
	localparam logic [4:0] FL_DEC = 5'b01000;
	localparam logic [4:0] FL_IRD = 5'b00100;
	localparam logic [4:0] FL_DRD = 5'b00010;
	localparam logic [4:0] FL_DWR = 5'b00001;
	localparam word_t RST_BIT = 22'h200000;
	localparam word_t IDLE_WORD = {1'b0, 1'b0, cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF,
		cu_pkg::ALU_IDLE, cu_pkg::INC_OFF, 5'b00000};

	logic clk;
	logic reset;
	cu_pkg::instr_t instruction;
	logic zflag;
	logic start_sig;
	cu_pkg::mux_sel_t mux_sig;
	cu_pkg::load_sel_t load_decode_sig;
	cu_pkg::alu_op_t alu_sig;
	cu_pkg::inc_sel_t inc_decode_sig;
	logic busy_sig;
	logic rst_PC;
	logic clear_ac;
	logic dec_ac;
	logic iram_read;
	logic dram_read;
	logic dram_write;

	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	logic timed_out;
	logic [31:0] rng;
	cu_pkg::instr_t ops[$];
	cu_pkg::cu_state_t sts[$];
	cu_pkg::cu_state_t exec_q[$];

	control_unit UUT
	(
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.zflag(zflag),
		.start_sig(start_sig),
		.mux_sig(mux_sig),
		.load_decode_sig(load_decode_sig),
		.alu_sig(alu_sig),
		.inc_decode_sig(inc_decode_sig),
		.busy_sig(busy_sig),
		.rst_PC(rst_PC),
		.clear_ac(clear_ac),
		.dec_ac(dec_ac),
		.iram_read(iram_read),
		.dram_read(dram_read),
		.dram_write(dram_write)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ----------------------------------------
	// expected control words
	// ----------------------------------------
	function automatic word_t word_of(input cu_pkg::mux_sel_t mux, input cu_pkg::load_sel_t load,
		input cu_pkg::inc_sel_t inc, input logic [4:0] flags);
		return {1'b0, 1'b1, mux, load, cu_pkg::ALU_IDLE, inc, flags};
	endfunction

	function automatic word_t alu_word(input cu_pkg::mux_sel_t mux, input cu_pkg::alu_op_t op,
		input cu_pkg::inc_sel_t inc);
		return {1'b0, 1'b1, mux, cu_pkg::LOAD_OFF, op, inc, 5'b00000};
	endfunction

	function automatic word_t expected_word(input cu_pkg::cu_state_t s);
		word_t w;
		w = IDLE_WORD;
		case (s)
			cu_pkg::S_FETCH1: w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_OFF, FL_IRD);
			cu_pkg::S_FETCH2: w = word_of(cu_pkg::SEL_IRAM, cu_pkg::LOAD_DR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_FETCH3: w = word_of(cu_pkg::SEL_DR, cu_pkg::LOAD_IR, cu_pkg::INC_PC, FL_NONE);
			cu_pkg::S_FETCH4: w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_NOP: w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_CLAC: w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_OFF, FL_CLR);
			// two-byte address, then two data bytes.
			cu_pkg::S_LDAC1: w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_OFF, FL_IRD);
			cu_pkg::S_LDAC2: w = word_of(cu_pkg::SEL_IRAM, cu_pkg::LOAD_DR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_LDAC3: w = word_of(cu_pkg::SEL_DR, cu_pkg::LOAD_TR, cu_pkg::INC_PC, FL_IRD);
			cu_pkg::S_LDAC4: w = word_of(cu_pkg::SEL_IRAM, cu_pkg::LOAD_DR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_LDAC5: w = word_of(cu_pkg::SEL_DRTR, cu_pkg::LOAD_AR, cu_pkg::INC_PC, FL_DRD);
			cu_pkg::S_LDAC6: w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_OFF, FL_DRD);
			cu_pkg::S_LDAC7: w = word_of(cu_pkg::SEL_DRAM, cu_pkg::LOAD_DR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_LDAC8: w = word_of(cu_pkg::SEL_DR, cu_pkg::LOAD_TR, cu_pkg::INC_AR, FL_DRD);
			cu_pkg::S_LDAC9: w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_OFF, FL_DRD);
			cu_pkg::S_LDAC10: w = word_of(cu_pkg::SEL_DRAM, cu_pkg::LOAD_DR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_LDAC11: w = word_of(cu_pkg::SEL_DRTR, cu_pkg::LOAD_AC, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_STAC1: w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_OFF, FL_IRD);
			cu_pkg::S_STAC2: w = word_of(cu_pkg::SEL_IRAM, cu_pkg::LOAD_DR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_STAC3: w = word_of(cu_pkg::SEL_DR, cu_pkg::LOAD_TR, cu_pkg::INC_PC, FL_IRD);
			cu_pkg::S_STAC4: w = word_of(cu_pkg::SEL_IRAM, cu_pkg::LOAD_DR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_STAC5: w = word_of(cu_pkg::SEL_DRTR, cu_pkg::LOAD_AR, cu_pkg::INC_PC, FL_NONE);
			cu_pkg::S_STAC6: w = word_of(cu_pkg::SEL_AC, cu_pkg::LOAD_DR, cu_pkg::INC_OFF, FL_DWR);
			cu_pkg::S_STAC7: w = word_of(cu_pkg::SEL_ACINV, cu_pkg::LOAD_DR, cu_pkg::INC_AR, FL_DWR);
			cu_pkg::S_MVR_SR: w = word_of(cu_pkg::SEL_SR, cu_pkg::LOAD_AC, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVR_CDR: w = word_of(cu_pkg::SEL_CDR, cu_pkg::LOAD_AC, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVR_A: w = word_of(cu_pkg::SEL_A, cu_pkg::LOAD_AC, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVR_CID: w = word_of(cu_pkg::SEL_CID, cu_pkg::LOAD_AC, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVR_CLA: w = word_of(cu_pkg::SEL_CLA, cu_pkg::LOAD_AC, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVAC_A: w = word_of(cu_pkg::SEL_AC, cu_pkg::LOAD_A, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVAC_B: w = word_of(cu_pkg::SEL_AC, cu_pkg::LOAD_B, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVAC_C: w = word_of(cu_pkg::SEL_AC, cu_pkg::LOAD_C, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVAC_CDR: w = word_of(cu_pkg::SEL_AC, cu_pkg::LOAD_CDR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVAC_SR: w = word_of(cu_pkg::SEL_AC, cu_pkg::LOAD_SR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVAC_PR: w = word_of(cu_pkg::SEL_AC, cu_pkg::LOAD_PR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVAC_R: w = word_of(cu_pkg::SEL_AC, cu_pkg::LOAD_R, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVAC_NOC: w = word_of(cu_pkg::SEL_AC, cu_pkg::LOAD_NOC, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MVAC_CLA: w = word_of(cu_pkg::SEL_AC, cu_pkg::LOAD_CLA, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_MUL_PR: w = alu_word(cu_pkg::SEL_PR, cu_pkg::ALU_MUL, cu_pkg::INC_OFF);
			cu_pkg::S_ADD_CDR: w = alu_word(cu_pkg::SEL_CDR, cu_pkg::ALU_ADD, cu_pkg::INC_OFF);
			cu_pkg::S_ADD_SR: w = alu_word(cu_pkg::SEL_SR, cu_pkg::ALU_ADD, cu_pkg::INC_OFF);
			cu_pkg::S_ADD_SR_IR: w = alu_word(cu_pkg::SEL_SR, cu_pkg::ALU_ADD, cu_pkg::INC_R);
			cu_pkg::S_SUB_R: w = alu_word(cu_pkg::SEL_R, cu_pkg::ALU_SUB, cu_pkg::INC_OFF);
			cu_pkg::S_SUB_CDR: w = alu_word(cu_pkg::SEL_CDR, cu_pkg::ALU_SUB, cu_pkg::INC_OFF);
			cu_pkg::S_DIV_NOC: w = alu_word(cu_pkg::SEL_NOC, cu_pkg::ALU_DIV, cu_pkg::INC_OFF);
			cu_pkg::S_JPNZ_Y1, cu_pkg::S_LAST_Y1:
				w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_OFF, FL_IRD);
			cu_pkg::S_JPNZ_Y2, cu_pkg::S_LAST_Y2:
				w = word_of(cu_pkg::SEL_IRAM, cu_pkg::LOAD_DR, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_JPNZ_Y3, cu_pkg::S_LAST_Y3:
				w = word_of(cu_pkg::SEL_DR, cu_pkg::LOAD_PC, cu_pkg::INC_OFF, FL_NONE);
			cu_pkg::S_JPNZ_N, cu_pkg::S_LAST_N:
				w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_PC, FL_NONE);
			cu_pkg::S_INCAC: w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_AC, FL_NONE);
			cu_pkg::S_DECAC: w = word_of(cu_pkg::SEL_NONE, cu_pkg::LOAD_OFF, cu_pkg::INC_OFF, FL_DEC);
			default: w = IDLE_WORD;
		endcase
		return w;
	endfunction

	function automatic word_t observed_word();
		return {rst_PC, busy_sig, mux_sig, load_decode_sig, alu_sig, inc_decode_sig,
			clear_ac, dec_ac, iram_read, dram_read, dram_write};
	endfunction

	function logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ----------------------------------------
	// checks and stepping
	// ----------------------------------------
	task automatic check_field(input string name, input word_t got, input word_t exp,
		input int lsb, input int width);
		word_t mask;
		mask = ((word_t'(1) << width) - word_t'(1)) << lsb;
		checks++;
		assert ((got & mask) === (exp & mask))
		else
		begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, (got & mask) >> lsb,
				(exp & mask) >> lsb);
		end
	endtask

	task automatic check_word(input word_t exp);
		word_t got;
		got = observed_word();
		check_field("rst_PC", got, exp, 21, 1);
		check_field("busy_sig", got, exp, 20, 1);
		check_field("mux_sig", got, exp, 15, 5);
		check_field("load_decode_sig", got, exp, 11, 4);
		check_field("alu_sig", got, exp, 8, 3);
		check_field("inc_decode_sig", got, exp, 5, 3);
		check_field("clear_ac", got, exp, 4, 1);
		check_field("dec_ac", got, exp, 3, 1);
		check_field("iram_read", got, exp, 2, 1);
		check_field("dram_read", got, exp, 1, 1);
		check_field("dram_write", got, exp, 0, 1);
	endtask

	task automatic tick();
		@(posedge clk);
		#2; // drive point after the edge.
	endtask

	task automatic launch();
		int n;
		start_sig = 1'b0;
		tick();
		n = 1;
		while (!rst_PC && n < TIMEOUT)
		begin
			tick();
			n++;
		end
		if (!rst_PC)
		begin
			timed_out = 1'b1;
			errors++;
			$display("timeout waiting for rst_PC after start_sig fell");
		end
		else
		begin
			assert (n == 1)
			else
			begin
				errors++;
				$display("rst_PC rose %0d cycles after start_sig fell, expected 1", n);
			end
			check_word(IDLE_WORD | RST_BIT);
		end
		start_sig = 1'b1; // stay idle at the next program end.
	endtask

	task automatic wait_idle();
		int n;
		tick();
		n = 1;
		while (busy_sig && n < TIMEOUT)
		begin
			tick();
			n++;
		end
		if (busy_sig)
		begin
			timed_out = 1'b1;
			errors++;
			$display("timeout waiting for busy_sig to fall");
		end
		else
		begin
			assert (n == 1)
			else
			begin
				errors++;
				$display("busy_sig fell %0d cycles after the last word, expected 1", n);
			end
			check_word(IDLE_WORD);
		end
		repeat (3)
		begin
			tick();
			check_word(IDLE_WORD);
		end
	endtask

	task automatic queue_chain(input cu_pkg::cu_state_t first, input int count);
		int i;
		exec_q.delete();
		for (i = 0; i < count; i++)
			exec_q.push_back(cu_pkg::cu_state_t'(int'(first) + i));
	endtask

	// fetch words, then the words queued in exec_q.
	task automatic run_instr(input cu_pkg::instr_t ins, input logic z);
		cu_pkg::cu_state_t seq[$];
		seq.push_back(cu_pkg::S_FETCH1);
		seq.push_back(cu_pkg::S_FETCH2);
		seq.push_back(cu_pkg::S_FETCH3);
		seq.push_back(cu_pkg::S_FETCH4);
		foreach (exec_q[i])
			seq.push_back(exec_q[i]);
		instruction = ins;
		zflag = z;
		foreach (seq[i])
		begin
			tick();
			check_word(expected_word(seq[i]));
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	task automatic add_op(input cu_pkg::opcode_t opc, input cu_pkg::operand_t opd,
		input cu_pkg::cu_state_t st);
		ops.push_back({opc, opd});
		sts.push_back(st);
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_reset_idle();
		int err_start;
		err_start = errors;
		check_word(IDLE_WORD);
		repeat (10)
		begin
			tick();
			check_word(IDLE_WORD);
		end
		report_test("reset_idle", err_start);
	endtask

	task automatic test_start();
		int err_start;
		err_start = errors;
		launch();
		queue_chain(cu_pkg::S_NOP, 1);
		run_instr({cu_pkg::NOP, 4'd0}, 1'b0);
		report_test("start", err_start);
	endtask

	task automatic test_single_cycle();
		int err_start;
		int idx;
		err_start = errors;
		add_op(cu_pkg::MVR, cu_pkg::OPD_SR, cu_pkg::S_MVR_SR);
		add_op(cu_pkg::MVR, cu_pkg::OPD_CDR, cu_pkg::S_MVR_CDR);
		add_op(cu_pkg::MVR, cu_pkg::OPD_A, cu_pkg::S_MVR_A);
		add_op(cu_pkg::MVR, cu_pkg::OPD_CID, cu_pkg::S_MVR_CID);
		add_op(cu_pkg::MVR, cu_pkg::OPD_CLA, cu_pkg::S_MVR_CLA);
		add_op(cu_pkg::MVAC, cu_pkg::OPD_A, cu_pkg::S_MVAC_A);
		add_op(cu_pkg::MVAC, cu_pkg::OPD_B, cu_pkg::S_MVAC_B);
		add_op(cu_pkg::MVAC, cu_pkg::OPD_C, cu_pkg::S_MVAC_C);
		add_op(cu_pkg::MVAC, cu_pkg::OPD_CDR, cu_pkg::S_MVAC_CDR);
		add_op(cu_pkg::MVAC, cu_pkg::OPD_SR, cu_pkg::S_MVAC_SR);
		add_op(cu_pkg::MVAC, cu_pkg::OPD_PR, cu_pkg::S_MVAC_PR);
		add_op(cu_pkg::MVAC, cu_pkg::OPD_R, cu_pkg::S_MVAC_R);
		add_op(cu_pkg::MVAC, cu_pkg::OPD_NOC, cu_pkg::S_MVAC_NOC);
		add_op(cu_pkg::MVAC, cu_pkg::OPD_CLA, cu_pkg::S_MVAC_CLA);
		add_op(cu_pkg::MUL, cu_pkg::OPD_PR, cu_pkg::S_MUL_PR);
		add_op(cu_pkg::ADD, cu_pkg::OPD_CDR, cu_pkg::S_ADD_CDR);
		add_op(cu_pkg::ADD, cu_pkg::OPD_SR, cu_pkg::S_ADD_SR);
		add_op(cu_pkg::ADD, cu_pkg::OPD_SR_IR, cu_pkg::S_ADD_SR_IR);
		add_op(cu_pkg::SUB, cu_pkg::OPD_R, cu_pkg::S_SUB_R);
		add_op(cu_pkg::SUB, cu_pkg::OPD_CDR, cu_pkg::S_SUB_CDR);
		add_op(cu_pkg::DIV, cu_pkg::OPD_NOC, cu_pkg::S_DIV_NOC);
		add_op(cu_pkg::CLAC, 4'd0, cu_pkg::S_CLAC);
		add_op(cu_pkg::NOP, 4'd0, cu_pkg::S_NOP);
		add_op(cu_pkg::INCAC, 4'd0, cu_pkg::S_INCAC);
		add_op(cu_pkg::DECAC, 4'd0, cu_pkg::S_DECAC);
		repeat (20)
		begin
			idx = int'(next_random() % 32'(ops.size()));
			queue_chain(sts[idx], 1);
			run_instr(ops[idx], 1'b0);
		end
		report_test("single_cycle", err_start);
	endtask

	task automatic test_ldac_stac();
		int err_start;
		err_start = errors;
		queue_chain(cu_pkg::S_LDAC1, 11);
		run_instr({cu_pkg::LDAC, cu_pkg::OPD_LOAD}, 1'b0);
		queue_chain(cu_pkg::S_STAC1, 7);
		run_instr({cu_pkg::STAC, cu_pkg::OPD_STORE}, 1'b0);
		report_test("ldac_stac", err_start);
	endtask

	task automatic test_jumps();
		int err_start;
		err_start = errors;
		queue_chain(cu_pkg::S_JPNZ_Y1, 3);
		run_instr({cu_pkg::JPNZ, cu_pkg::OPD_JUMP}, 1'b0);
		queue_chain(cu_pkg::S_JPNZ_N, 1);
		run_instr({cu_pkg::JPNZ, cu_pkg::OPD_JUMP}, 1'b1);
		queue_chain(cu_pkg::S_LAST_N, 1);
		run_instr({cu_pkg::JPNZ, cu_pkg::OPD_LAST}, 1'b1);
		queue_chain(cu_pkg::S_LAST_Y1, 3);
		run_instr({cu_pkg::JPNZ, cu_pkg::OPD_LAST}, 1'b0);
		wait_idle();
		// program end.
		launch();
		queue_chain(cu_pkg::S_NOP, 0);
		run_instr({cu_pkg::END_PRG, 4'd0}, 1'b0);
		wait_idle();
		// MVR has no operand 0.
		launch();
		run_instr({cu_pkg::MVR, 4'd0}, 1'b0);
		wait_idle();
		report_test("jumps", err_start);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		rng = 32'd59862;
		reset = 1'b1;
		start_sig = 1'b1;
		instruction = '0;
		zflag = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;

		test_reset_idle();
		test_start();
		test_single_cycle();
		test_ldac_stac();
		test_jumps();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && !timed_out)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
design/cu_pkg.sv
design/instr_decoder.sv
design/micro_sequencer.sv
design/control_store.sv
design/control_unit.sv
sim/tb_control_unit.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       ?= tb_control_unit
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -x "Regression passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
